//--- dv/tb_clock_gen.sv
//============================================================
// Testbench clock and reset source
//============================================================

module tb_clock_gen (
    output logic clk_sys,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_sys = 1'b0;
        forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
    end

    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_sys);
        rst_n <= 1'b1;  // Released on a rising edge
    end

endmodule

//--- dv/tb_f2_glue.sv
//============================================================
// F2 glue testbench
// Directed tests for DIP capture, save states, reset, SDRAM share
//============================================================
`include "f2_glue_defs.svh"

module tb_f2_glue;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TEST_CYCLES    = 120;                  // Rough length of all tests
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES + 40;

    logic                    clk_sys;
    logic                    rst_n;
    f2_ctrl_pkg::ioctl_wr_t  ioctl;
    logic [`F2_STATUS_W-1:0] status;
    logic                    user_button;
    logic                    loader_busy;
    f2_mem_pkg::sdr_req_t    loader_sdr;
    logic                    loader_ack;
    f2_mem_pkg::sdr_rd_t     cpu_rd;
    f2_mem_pkg::sdr_rsp_t    cpu_rsp;
    f2_mem_pkg::sdr_req_t    ch3;
    f2_mem_pkg::sdr_rsp_t    ch3_rsp;
    f2_ctrl_pkg::dsw_t       dsw;
    f2_ctrl_pkg::ss_req_t    ss_req;
    logic                    core_reset;

    integer            seed;
    int                error_count;
    int                check_count;
    int                test_count;
    int                failed_tests;
    int                cycle_count;
    f2_ctrl_pkg::dsw_t exp_dsw;  // Model of the switch settings

    tb_clock_gen clock_gen_i (.clk_sys(clk_sys), .rst_n(rst_n));

    f2_glue_top dut_i (
        .clk_sys(clk_sys), .rst_n(rst_n), .ioctl(ioctl), .status(status),
        .user_button(user_button), .loader_busy(loader_busy),
        .loader_sdr(loader_sdr), .loader_ack(loader_ack), .cpu_rd(cpu_rd),
        .cpu_rsp(cpu_rsp), .ch3(ch3), .ch3_rsp(ch3_rsp), .dsw(dsw),
        .ss_req(ss_req), .core_reset(core_reset)
    );

    //============================================================
    // Compare tasks
    //============================================================
    task automatic check_dsw(input string name, input f2_ctrl_pkg::dsw_t got,
                             input f2_ctrl_pkg::dsw_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_ss(input string name, input f2_ctrl_pkg::ss_req_t got,
                            input f2_ctrl_pkg::ss_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_sdr(input string name, input f2_mem_pkg::sdr_req_t got,
                             input f2_mem_pkg::sdr_req_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rsp(input string name, input f2_mem_pkg::sdr_rsp_t got,
                             input f2_mem_pkg::sdr_rsp_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] t=%0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("Test %0d (%s): passed", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d (%s): failed", test_count, name);
        end
    endtask

    //============================================================
    // Stimulus helpers
    //============================================================
    // Byte that differs from both stored bytes, so a stray write shows up
    function automatic logic [7:0] fresh_byte();
        logic [31:0] rnd;
        rnd = $random(seed);
        while (rnd[7:0] == ~exp_dsw.dswa || rnd[7:0] == ~exp_dsw.dswb) begin
            rnd = $random(seed);
        end
        return rnd[7:0];
    endfunction

    task automatic write_dip(input logic [7:0] index, input logic [24:0] addr,
                             input logic [7:0] data);
        @(posedge clk_sys);
        ioctl.wr    <= 1'b1;
        ioctl.index <= index;
        ioctl.addr  <= addr;
        ioctl.data  <= data;
        @(negedge clk_sys);
        check_dsw("dsw before capture", dsw, exp_dsw);
        @(posedge clk_sys);
        ioctl.wr <= 1'b0;
        @(negedge clk_sys);
    endtask

    task automatic set_status(input logic [`F2_STATUS_W-1:0] value);
        @(posedge clk_sys);
        status <= value;
        @(posedge clk_sys);
        @(negedge clk_sys);  // Registered one cycle later
    endtask

    //============================================================
    // Tests
    //============================================================
    task automatic test_reset_and_dip();
        int         errs;
        logic [7:0] data;
        errs = error_count;
        @(posedge clk_sys);
        repeat (3) begin  // Two reset cycles and the stretch cycle
            @(negedge clk_sys);
            check_bit("core_reset", core_reset, 1'b1);
        end
        @(negedge clk_sys);
        check_bit("core_reset", core_reset, 1'b0);
        check_dsw("dsw", dsw, exp_dsw);
        check_ss("ss_req", ss_req, '0);
        for (int k = 0; k < 4; k++) begin
            data = fresh_byte();
            write_dip(8'(`F2_IOCTL_DIP_INDEX), 25'(k % 2), data);
            if (k % 2 == 0) exp_dsw.dswa = ~data;
            else            exp_dsw.dswb = ~data;
            check_dsw("dsw", dsw, exp_dsw);
        end
        finish_test("reset and DIP capture", errs);
    endtask

    task automatic test_dip_filter();
        int errs;
        errs = error_count;
        write_dip(8'd253, 25'd0, fresh_byte());                          // Wrong index
        check_dsw("dsw", dsw, exp_dsw);
        write_dip(8'(`F2_IOCTL_DIP_INDEX), 25'h8, fresh_byte());         // Bit 3 set
        check_dsw("dsw", dsw, exp_dsw);
        write_dip(8'(`F2_IOCTL_DIP_INDEX), 25'h100_0001, fresh_byte());  // Top bit set
        check_dsw("dsw", dsw, exp_dsw);
        for (int b = 2; b < 8; b++) begin
            write_dip(8'(`F2_IOCTL_DIP_INDEX), 25'(b), fresh_byte());
            check_dsw("dsw", dsw, exp_dsw);
        end
        finish_test("DIP write filter", errs);
    endtask

    task automatic test_save_states();
        int                      errs;
        logic [`F2_STATUS_W-1:0] st;
        f2_ctrl_pkg::ss_req_t    exp;
        errs = error_count;
        for (int i = 0; i < 2 * `F2_SS_SLOTS; i++) begin
            st = '0;
            st[`F2_STATUS_SAVE_LSB + i] = 1'b1;  // Load field follows save field
            set_status(st);
            exp.index      = 2'(i % `F2_SS_SLOTS);
            exp.do_save    = (i < `F2_SS_SLOTS);
            exp.do_restore = (i >= `F2_SS_SLOTS);
            check_ss("ss_req", ss_req, exp);
        end
        st = '0;
        st[`F2_STATUS_SAVE_LSB + 1] = 1'b1;
        st[`F2_STATUS_SAVE_LSB + 2] = 1'b1;
        set_status(st);
        check_ss("ss_req", ss_req, {2'd0, 1'b1, 1'b0});
        st = '0;
        st[`F2_STATUS_LOAD_LSB + 2] = 1'b1;
        set_status(st);
        check_ss("ss_req", ss_req, {2'd2, 1'b0, 1'b1});
        st[`F2_STATUS_SAVE_LSB + 3] = 1'b1;
        set_status(st);
        check_ss("ss_req", ss_req, {2'd0, 1'b1, 1'b1});
        st = '0;
        st[`F2_STATUS_LOAD_LSB + 3] = 1'b1;
        set_status(st);
        check_ss("ss_req", ss_req, {2'd3, 1'b0, 1'b1});
        set_status('0);  // Levels drop, slot holds
        check_ss("ss_req", ss_req, {2'd3, 1'b0, 1'b0});
        finish_test("save-state decode", errs);
    endtask

    task automatic test_reset_sources();
        int errs;
        errs = error_count;
        for (int src = 0; src < 3; src++) begin
            @(negedge clk_sys);
            check_bit("core_reset idle", core_reset, 1'b0);
            @(posedge clk_sys);
            case (src)
                0:       status[`F2_STATUS_RESET_BIT] <= 1'b1;
                1:       user_button <= 1'b1;
                default: loader_busy <= 1'b1;
            endcase
            @(negedge clk_sys);
            check_bit("core_reset early", core_reset, 1'b0);
            @(posedge clk_sys);
            status[`F2_STATUS_RESET_BIT] <= 1'b0;
            user_button <= 1'b0;
            loader_busy <= 1'b0;
            @(negedge clk_sys);
            check_bit("core_reset", core_reset, 1'b1);
        end
        @(negedge clk_sys);
        check_bit("core_reset after", core_reset, 1'b0);
        finish_test("core reset sources", errs);
    endtask

    task automatic test_port_share();
        int                   errs;
        logic [31:0]          r0;
        logic [31:0]          r1;
        logic [31:0]          r2;
        logic                 busy;
        f2_mem_pkg::sdr_req_t ld;
        f2_mem_pkg::sdr_rd_t  cpu;
        f2_mem_pkg::sdr_rsp_t rsp;
        f2_mem_pkg::sdr_req_t exp_ch3;
        errs = error_count;
        for (int k = 0; k < 8; k++) begin
            busy = (k < 4);
            r0 = $random(seed);
            r1 = $random(seed);
            r2 = $random(seed);
            ld  = {r0[0], r0[1], r0[3:2], r1[26:0], r2[15:0]};
            cpu = {r0[4], r2[31:5]};
            rsp = {k[0], r1, r2};  // Both ack levels in each mode
            @(posedge clk_sys);
            loader_busy <= busy;
            loader_sdr  <= ld;
            cpu_rd      <= cpu;
            ch3_rsp     <= rsp;
            @(negedge clk_sys);
            exp_ch3 = busy ? ld : {cpu.req, 1'b1, 2'b00, cpu.addr, ld.din};
            check_sdr("ch3", ch3, exp_ch3);
            check_bit("loader_ack", loader_ack, busy ? rsp.ack : ld.req);
            check_rsp("cpu_rsp", cpu_rsp, {busy ? cpu.req : rsp.ack, rsp.q});
        end
        @(posedge clk_sys);
        loader_busy <= 1'b0;
        finish_test("shared SDRAM port", errs);
    endtask

    //============================================================
    // Main sequence and timeout
    //============================================================
    initial begin
        seed         = 14485;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        exp_dsw      = '1;  // Nothing stored yet
        ioctl        <= '0;
        status       <= '0;
        user_button  <= 1'b0;
        loader_busy  <= 1'b0;
        loader_sdr   <= '0;
        cpu_rd       <= '0;
        ch3_rsp      <= '0;
        test_reset_and_dip();
        test_dip_filter();
        test_save_states();
        test_reset_sources();
        test_port_share();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_sys);
            cycle_count++;
        end
        $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- f2_glue.f
+incdir+hdl
hdl/f2_ctrl_pkg.sv
hdl/f2_mem_pkg.sv
hdl/ioctl_capture.sv
hdl/core_control.sv
hdl/sdram_port_share.sv
hdl/f2_glue_top.sv
dv/tb_clock_gen.sv
dv/tb_f2_glue.sv

//--- hdl/core_control.sv
//============================================================
// Save-state request decode and combined core reset
//============================================================
`include "f2_glue_defs.svh"

module core_control (
    input  logic                     clk_sys,
    input  logic                     rst_n,
    input  logic [`F2_STATUS_W-1:0]  status,
    input  logic                     user_button,
    input  logic                     loader_busy,
    output f2_ctrl_pkg::ss_req_t     ss_req,
    output logic                     core_reset
);

    logic [`F2_SS_SLOTS-1:0] save_bits;
    logic [`F2_SS_SLOTS-1:0] load_bits;
    logic [`F2_SS_SLOTS-1:0] any_bits;
    f2_ctrl_pkg::ss_index_t  slot_idx;
    logic                    reset_hold;

    //============================================================
    // Save states
    //============================================================
    assign save_bits = status[`F2_STATUS_SAVE_LSB +: `F2_SS_SLOTS];
    assign load_bits = status[`F2_STATUS_LOAD_LSB +: `F2_SS_SLOTS];
    assign any_bits  = save_bits | load_bits;

    // Position of the single set bit, 0 when ambiguous
    always_comb begin
        slot_idx = '0;
        for (int i = 0; i < `F2_SS_SLOTS; i++) begin
            if (any_bits[i]) slot_idx = f2_ctrl_pkg::ss_index_t'(i);
        end
        if (!$onehot(any_bits)) slot_idx = '0;
    end

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            ss_req <= '0;
        end else if (|any_bits) begin
            ss_req.index      <= slot_idx;
            ss_req.do_save    <= |save_bits;
            ss_req.do_restore <= |load_bits;
        end else begin
            ss_req.do_save    <= 1'b0;  // Index holds
            ss_req.do_restore <= 1'b0;
        end
    end

    //============================================================
    // Core reset
    //============================================================
    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            reset_hold <= 1'b1;
            core_reset <= 1'b1;
        end else begin
            reset_hold <= 1'b0;   // Stretches reset by one cycle
            core_reset <= reset_hold | status[`F2_STATUS_RESET_BIT] |
                          user_button | loader_busy;
        end
    end

    // A ROM load must keep the core in reset
    a_load_resets: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        loader_busy |=> core_reset
    ) else $error("core_reset low after loader_busy");

endmodule

//--- hdl/f2_ctrl_pkg.sv
//============================================================
// F2 glue control types: download writes, DIPs, save states
//============================================================
`include "f2_glue_defs.svh"

package f2_ctrl_pkg;

    typedef struct packed {
        logic                         wr;     // One-cycle write strobe
        logic [7:0]                   index;
        logic [`F2_IOCTL_ADDR_W-1:0]  addr;
        logic [7:0]                   data;
    } ioctl_wr_t;

    // Active-low switch settings as the core expects them
    typedef struct packed {
        logic [7:0] dswa;
        logic [7:0] dswb;
    } dsw_t;

    typedef logic [$clog2(`F2_SS_SLOTS)-1:0] ss_index_t;

    typedef struct packed {
        ss_index_t index;
        logic      do_save;
        logic      do_restore;
    } ss_req_t;

endpackage

//--- hdl/f2_glue_defs.svh
//============================================================
// F2 glue shared widths, indices and status bit positions
//============================================================
`ifndef F2_GLUE_DEFS_SVH
`define F2_GLUE_DEFS_SVH

// Download channel
`define F2_IOCTL_ADDR_W      25
`define F2_IOCTL_DIP_INDEX   254
`define F2_DIP_BANKS_USED    2     // Only DSWA and DSWB are read by the core

// Menu status word
`define F2_STATUS_W          128
`define F2_STATUS_RESET_BIT  0
`define F2_STATUS_SAVE_LSB   64    // Save State 1..4
`define F2_STATUS_LOAD_LSB   68    // Load State 1..4
`define F2_SS_SLOTS          4

// Shared SDRAM channel
`define F2_SDR_ADDR_W        27
`define F2_SDR_DIN_W         16
`define F2_SDR_Q_W           64

`endif

//--- hdl/f2_glue_top.sv
//============================================================
// F2 glue top level
// DIP capture, core control and shared SDRAM channel
//============================================================
`include "f2_glue_defs.svh"

module f2_glue_top (
    input  logic                     clk_sys,
    input  logic                     rst_n,

    // Download channel and menu
    input  f2_ctrl_pkg::ioctl_wr_t   ioctl,
    input  logic [`F2_STATUS_W-1:0]  status,
    input  logic                     user_button,

    // ROM loader
    input  logic                     loader_busy,
    input  f2_mem_pkg::sdr_req_t     loader_sdr,
    output logic                     loader_ack,

    // CPU read port
    input  f2_mem_pkg::sdr_rd_t      cpu_rd,
    output f2_mem_pkg::sdr_rsp_t     cpu_rsp,

    // SDRAM channel 3
    output f2_mem_pkg::sdr_req_t     ch3,
    input  f2_mem_pkg::sdr_rsp_t     ch3_rsp,

    // To the core
    output f2_ctrl_pkg::dsw_t        dsw,
    output f2_ctrl_pkg::ss_req_t     ss_req,
    output logic                     core_reset
);

    //============================================================
    // Blocks
    //============================================================
    ioctl_capture ioctl_capture_i (
        .clk_sys  (clk_sys),
        .rst_n    (rst_n),
        .ioctl    (ioctl),
        .dsw      (dsw)
    );

    core_control core_control_i (
        .clk_sys     (clk_sys),
        .rst_n       (rst_n),
        .status      (status),
        .user_button (user_button),
        .loader_busy (loader_busy),  // ROM load holds core in reset
        .ss_req      (ss_req),
        .core_reset  (core_reset)
    );

    sdram_port_share sdram_port_share_i (
        .clk_sys     (clk_sys),
        .loader_busy (loader_busy),
        .loader_sdr  (loader_sdr),
        .loader_ack  (loader_ack),
        .cpu_rd      (cpu_rd),
        .cpu_rsp     (cpu_rsp),
        .ch3         (ch3),
        .ch3_rsp     (ch3_rsp)
    );

endmodule

//--- hdl/f2_mem_pkg.sv
//============================================================
// F2 glue SDRAM channel request and response types
//============================================================
`include "f2_glue_defs.svh"

package f2_mem_pkg;

    // Full channel request, used by the loader and channel 3
    typedef struct packed {
        logic                        req;
        logic                        rnw;    // 1 read, 0 write
        logic [1:0]                  be;
        logic [`F2_SDR_ADDR_W-1:0]   addr;
        logic [`F2_SDR_DIN_W-1:0]    din;
    } sdr_req_t;

    // CPU side only reads
    typedef struct packed {
        logic                        req;
        logic [`F2_SDR_ADDR_W-1:0]   addr;
    } sdr_rd_t;

    typedef struct packed {
        logic                        ack;
        logic [`F2_SDR_Q_W-1:0]      q;
    } sdr_rsp_t;

endpackage

//--- hdl/ioctl_capture.sv
//============================================================
// DIP switch capture from the download channel
// Stores banks 0 and 1, presents them active low
//============================================================
`include "f2_glue_defs.svh"

module ioctl_capture (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  f2_ctrl_pkg::ioctl_wr_t ioctl,
    output f2_ctrl_pkg::dsw_t      dsw
);

    logic [7:0] dip_q [`F2_DIP_BANKS_USED];
    logic [2:0] bank_sel;
    logic       dip_hit;
    logic       dip_wr;

    assign bank_sel = ioctl.addr[2:0];

    // DIP data lives at index 254, addresses 0..7
    assign dip_hit = (ioctl.index == 8'(`F2_IOCTL_DIP_INDEX)) &&
                     (ioctl.addr[`F2_IOCTL_ADDR_W-1:3] == '0);

    // Banks 2..7 are never read, drop them here
    assign dip_wr = ioctl.wr && dip_hit && (bank_sel < 3'(`F2_DIP_BANKS_USED));

    always_ff @(posedge clk_sys) begin
        if (!rst_n) begin
            for (int b = 0; b < `F2_DIP_BANKS_USED; b++) begin
                dip_q[b] <= 8'h00;
            end
        end else begin
            for (int b = 0; b < `F2_DIP_BANKS_USED; b++) begin
                if (dip_wr && (bank_sel == 3'(b))) begin
                    dip_q[b] <= ioctl.data;
                end
            end
        end
    end

    assign dsw.dswa = ~dip_q[0];  // Core wants active low
    assign dsw.dswb = ~dip_q[1];

    // The write strobe must be a clean level once out of reset
    a_wr_known: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !$isunknown(ioctl.wr)
    ) else $error("ioctl.wr is unknown");

endmodule

//--- hdl/sdram_port_share.sv
//============================================================
// Shared SDRAM channel 3 steering between ROM loader and CPU
// The idle requester gets its own request echoed as ack
//============================================================

module sdram_port_share (
    input  logic                  clk_sys,
    input  logic                  loader_busy,
    input  f2_mem_pkg::sdr_req_t  loader_sdr,
    output logic                  loader_ack,
    input  f2_mem_pkg::sdr_rd_t   cpu_rd,
    output f2_mem_pkg::sdr_rsp_t  cpu_rsp,
    output f2_mem_pkg::sdr_req_t  ch3,
    input  f2_mem_pkg::sdr_rsp_t  ch3_rsp
);

    f2_mem_pkg::sdr_req_t cpu_req;

    // CPU side is read only
    always_comb begin
        cpu_req      = '0;
        cpu_req.req  = cpu_rd.req;
        cpu_req.rnw  = 1'b1;
        cpu_req.be   = 2'b00;
        cpu_req.addr = cpu_rd.addr;
        cpu_req.din  = loader_sdr.din;  // Unused on reads
    end

    // Loader owns the channel for the whole download
    always_comb begin
        if (loader_busy) begin
            ch3         = loader_sdr;
            loader_ack  = ch3_rsp.ack;
            cpu_rsp.ack = cpu_rd.req;   // Keeps the CPU from stalling
        end else begin
            ch3         = cpu_req;
            loader_ack  = loader_sdr.req;
            cpu_rsp.ack = ch3_rsp.ack;
        end
        cpu_rsp.q = ch3_rsp.q;
    end

    // Only the loader may write SDRAM
    a_no_cpu_write: assert property (
        @(posedge clk_sys)
        !(ch3.req && !ch3.rnw && !loader_busy)
    ) else $error("SDRAM write on ch3 outside ROM load");

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the f2_glue testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_f2_glue \
    --Mdir obj_dir \
    -o tb_f2_glue \
    -f f2_glue.f

# The simulation result is taken from the log, not from the exit status
./obj_dir/tb_f2_glue > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
